// File: mmu_top.f
+incdir+.
mmu_pkg.sv
mmu_if.sv
tlb_ram.sv
tlb_array.sv
tlb_lookup.sv
page_walker.sv
mmu_top.sv
tb_clock.sv
tb_mem.sv
tb_mmu_top.sv

// File: run_sim.sh
#!/bin/sh
# build the mmu testbench with verilator, run it, look for the pass line
verilator --binary --timing --top-module tb_mmu_top -f mmu_top.f -o tb_mmu_top &&
	./obj_dir/tb_mmu_top | tee /dev/stderr | grep -qF '** PASS **' &&
	echo "run_sim: simulation passed" ||
	{ echo "run_sim: simulation failed"; exit 1; }

// File: tb_mmu_top.sv
`timescale 1ns/1ps

module tb_mmu_top
	import mmu_pkg::*;
();

	localparam padr_t PTA_MAIN = 32'h0000_1000;
	localparam padr_t PTA_ALT  = 32'h0000_f000;   // same tables, new base

	typedef enum {OP_THRU, OP_WALK, OP_HIT, OP_FAULT, OP_INV, OP_PTA} op_e;

	typedef struct {
		string name;
		op_e   op;
		logic  paging;
		logic  is_data;
		vadr_t vadr;
		logic  wr;
		pte_t  leaf;      // leaf in memory, or the faulting entry
		logic  l1_bad;    // leaf goes in the level-1 slot instead
	} row_t;

	row_t rows [$];

	logic        clk, rst;
	logic        paging_en, invalidate, invalidate_all;
	padr_t       pta;
	logic        clr_code_npf, clr_data_npf;
	logic        code_npf, data_npf;
	pte_t        npf_pte;
	logic        code_av, data_av, data_wr;
	vadr_t       code_vadr, data_vadr;
	xlat_t       code_xlat, data_xlat;
	logic        code_rdy, data_rdy;
	logic        cyc, stb, we, ack;
	padr_t       adr;
	logic [31:0] dat_w, dat_r;

	tb_clock i_clock (.clk_o(clk), .rst_o(rst));

	tb_mem i_mem (
		.clk_i (clk), .rst_i (rst), .cyc_i (cyc), .stb_i (stb), .we_i (we),
		.adr_i (adr), .dat_i (dat_w), .ack_o (ack), .dat_o (dat_r)
	);

	mmu_top i_mmu_top (
		.clk_i            (clk),
		.rst_i            (rst),
		.paging_en_i      (paging_en),
		.invalidate_i     (invalidate),
		.invalidate_all_i (invalidate_all),
		.pta_i            (pta),
		.clr_code_npf_i   (clr_code_npf),
		.clr_data_npf_i   (clr_data_npf),
		.code_npf_o       (code_npf),
		.data_npf_o       (data_npf),
		.npf_pte_o        (npf_pte),
		.code_av_i        (code_av),
		.code_vadr_i      (code_vadr),
		.code_xlat_o      (code_xlat),
		.code_rdy_o       (code_rdy),
		.data_av_i        (data_av),
		.data_vadr_i      (data_vadr),
		.data_wr_i        (data_wr),
		.data_xlat_o      (data_xlat),
		.data_rdy_o       (data_rdy),
		.cyc_o            (cyc),
		.stb_o            (stb),
		.we_o             (we),
		.adr_o            (adr),
		.dat_o            (dat_w),
		.ack_i            (ack),
		.dat_i            (dat_r)
	);

	// ----------------------------------------------------------
	// expected values
	// ----------------------------------------------------------
	function automatic xlat_t thru_xlat(input vadr_t va);
		xlat_t x;
		x       = '0;        // supervisor, full access
		x.padr  = va;
		x.cache = 1'b1;
		x.rd    = 1'b1;
		x.wr    = 1'b1;
		x.exec  = 1'b1;
		x.valid = 1'b1;
		return x;
	endfunction

	function automatic xlat_t leaf_xlat(input vadr_t va, input pte_t leaf);
		xlat_t x;
		x.padr  = {leaf.ppn, va[11:0]};   // page offset kept
		x.priv  = leaf.priv;
		x.cache = leaf.cache;
		x.rd    = leaf.rd;
		x.wr    = leaf.wr;
		x.exec  = leaf.exec;
		x.valid = leaf.rd | leaf.wr | leaf.exec;
		return x;
	endfunction

	function automatic pte_t wb_pte(input pte_t leaf, input logic dirty);
		pte_t p;
		p          = leaf;
		p.accessed = 1'b1;
		p.dirty    = leaf.dirty | dirty;
		return p;
	endfunction

	function automatic logic rdy_of(input logic is_data);
		return is_data ? data_rdy : code_rdy;
	endfunction

	function automatic logic npf_of(input logic is_data);
		return is_data ? data_npf : code_npf;
	endfunction

	function automatic xlat_t xlat_of(input logic is_data);
		return is_data ? data_xlat : code_xlat;
	endfunction

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_xlat(input string name, input xlat_t exp, input xlat_t act);
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_pte(input string name, input pte_t exp, input pte_t act);
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_adr(input string name, input padr_t exp, input padr_t act);
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	task automatic add_row(input string name, input op_e op, input logic paging,
			input logic is_data, input vadr_t vadr, input logic wr, input pte_t leaf,
			input logic l1_bad);
		row_t r;
		r.name    = name;
		r.op      = op;
		r.paging  = paging;
		r.is_data = is_data;
		r.vadr    = vadr;
		r.wr      = wr;
		r.leaf    = leaf;
		r.l1_bad  = l1_bad;
		rows.push_back(r);
	endtask

	task automatic build_rows();
		add_row("thru_paging_off", OP_THRU, 1'b0, 1'b0, 32'h1234_5678, 1'b0, '0, 1'b0);
		add_row("thru_low_half", OP_THRU, 1'b1, 1'b1, 32'h0000_9abc, 1'b0, '0, 1'b0);
		add_row("code_miss", OP_WALK, 1'b1, 1'b0, 32'h0040_3123, 1'b0, 32'h00ab_c02d, 1'b0);
		add_row("code_hit", OP_HIT, 1'b1, 1'b0, 32'h0040_3ffc, 1'b0, 32'h00ab_c02d, 1'b0);
		add_row("data_rd_miss", OP_WALK, 1'b1, 1'b1, 32'h0080_7010, 1'b0, 32'h00de_f00b, 1'b0);
		add_row("data_rd_hit", OP_HIT, 1'b1, 1'b1, 32'h0080_7abc, 1'b0, 32'h00de_f00b, 1'b0);
		add_row("data_wr_miss", OP_WALK, 1'b1, 1'b1, 32'h0080_8020, 1'b1, 32'h0012_300f, 1'b0);
		add_row("code_leaf_fault", OP_FAULT, 1'b1, 1'b0, 32'h00c0_1000, 1'b0, 32'h0004_5600, 1'b0);
		add_row("data_l1_fault", OP_FAULT, 1'b1, 1'b1, 32'h0100_2000, 1'b0, 32'h0007_7770, 1'b1);
		add_row("inv_all", OP_INV, 1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
		add_row("code_after_inv", OP_WALK, 1'b1, 1'b0, 32'h0040_3123, 1'b0, 32'h00ab_c02d, 1'b0);
		add_row("pta_change", OP_PTA, 1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
		add_row("code_after_pta", OP_WALK, 1'b1, 1'b0, 32'h0040_3123, 1'b0, 32'h00ab_c02d, 1'b0);
		// five pages in set 5, the fifth evicts way 0
		add_row("repl_a", OP_WALK, 1'b1, 1'b1, 32'h0041_5000, 1'b0, 32'h0a00_1003, 1'b0);
		add_row("repl_b", OP_WALK, 1'b1, 1'b1, 32'h0081_5004, 1'b0, 32'h0b00_101b, 1'b0);
		add_row("repl_c", OP_WALK, 1'b1, 1'b1, 32'h00c1_5008, 1'b0, 32'h0c00_2005, 1'b0);
		add_row("repl_d", OP_WALK, 1'b1, 1'b1, 32'h0141_500c, 1'b0, 32'h0d00_300f, 1'b0);
		add_row("repl_e", OP_WALK, 1'b1, 1'b1, 32'h0181_5010, 1'b0, 32'h0e00_4007, 1'b0);
		add_row("repl_b_hit", OP_HIT, 1'b1, 1'b1, 32'h0081_5100, 1'b0, 32'h0b00_101b, 1'b0);
		add_row("repl_a_again", OP_WALK, 1'b1, 1'b1, 32'h0041_5200, 1'b0, 32'h0a00_1003, 1'b0);
	endtask

	task automatic drive_access(input row_t r);
		@(negedge clk);
		paging_en = r.paging;
		if (r.is_data) begin
			data_av   = 1'b1;
			data_vadr = r.vadr;
			data_wr   = r.wr;
		end else begin
			code_av   = 1'b1;
			code_vadr = r.vadr;
		end
		#2;   // settle, comb outputs sampled mid low phase
	endtask

	task automatic drop_access();
		@(negedge clk);
		code_av = 1'b0;
		data_av = 1'b0;
		data_wr = 1'b0;
	endtask

	task automatic wait_rdy(input row_t r);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < 200 && !seen; n++) begin
			@(negedge clk);
			#2;
			seen = rdy_of(r.is_data);
		end
		if (!seen)
			report_error({r.name, ": timeout, rdy did not rise after the miss"});
	endtask

	task automatic wait_npf(input row_t r);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < 200 && !seen; n++) begin
			@(negedge clk);
			#2;
			seen = npf_of(r.is_data);
		end
		if (!seen)
			report_error({r.name, ": timeout, page fault flag did not rise"});
	endtask

	task automatic run_row(input row_t r);
		int rds;
		int wrs;
		rds = i_mem.rd_count;
		wrs = i_mem.wr_count;
		case (r.op)
			OP_THRU, OP_HIT: begin
				drive_access(r);
				check_bit({r.name, " rdy"}, 1'b1, rdy_of(r.is_data));
				check_xlat(r.name, (r.op == OP_THRU) ? thru_xlat(r.vadr) :
					leaf_xlat(r.vadr, r.leaf), xlat_of(r.is_data));
				repeat (2) @(negedge clk);   // a walk would have opened cyc by now
				check_bit({r.name, " bus idle"}, 1'b1, i_mem.rd_count == rds && !cyc);
				drop_access();
			end
			OP_WALK: begin
				drive_access(r);
				check_bit({r.name, " miss"}, 1'b0, rdy_of(r.is_data));
				wait_rdy(r);
				check_xlat(r.name, leaf_xlat(r.vadr, r.leaf), xlat_of(r.is_data));
				check_bit({r.name, " two table reads"}, 1'b1, i_mem.rd_count == rds + 2);
				check_bit({r.name, " one write-back"}, 1'b1, i_mem.wr_count == wrs + 1);
				check_adr({r.name, " wb adr"}, i_mem.leaf_adr(r.vadr), i_mem.last_adr);
				check_pte({r.name, " wb pte"}, wb_pte(r.leaf, r.is_data && r.wr), i_mem.last_dat);
				drop_access();
			end
			OP_FAULT: begin
				drive_access(r);
				wait_npf(r);
				check_pte({r.name, " npf pte"}, r.leaf, npf_pte);
				check_bit({r.name, " other side"}, 1'b0, npf_of(!r.is_data));
				check_bit({r.name, " no write-back"}, 1'b1, i_mem.wr_count == wrs);
				drop_access();
				clr_code_npf = !r.is_data;   // clear lands with the access gone
				clr_data_npf = r.is_data;
				@(negedge clk);
				clr_code_npf = 1'b0;
				clr_data_npf = 1'b0;
				#2;
				check_bit({r.name, " flag cleared"}, 1'b0, npf_of(r.is_data));
			end
			OP_INV: begin
				@(negedge clk);
				invalidate_all = 1'b1;
				@(negedge clk);
				invalidate_all = 1'b0;
			end
			OP_PTA: begin
				@(negedge clk);
				pta = PTA_ALT;
				@(negedge clk);   // array drops all valid bits on this edge
			end
			default: report_error({r.name, ": row has an unknown kind"});
		endcase
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		paging_en      = 1'b1;
		invalidate     = 1'b0;
		invalidate_all = 1'b0;
		pta            = PTA_MAIN;
		clr_code_npf   = 1'b0;
		clr_data_npf   = 1'b0;
		code_av        = 1'b0;
		code_vadr      = '0;
		data_av        = 1'b0;
		data_vadr      = '0;
		data_wr        = 1'b0;
		build_rows();

		@(negedge clk);   // memory fill is done, lay the tables over it
		foreach (rows[i])
			if (rows[i].op inside {OP_WALK, OP_HIT, OP_FAULT})
				i_mem.map_page(rows[i].vadr, rows[i].leaf, rows[i].l1_bad, PTA_MAIN, PTA_ALT);

		for (int n = 0; n < 50 && rst; n++)
			@(negedge clk);
		if (rst)
			report_error("reset was never released");
		check_bit("reset cyc", 1'b0, cyc);
		check_bit("reset stb", 1'b0, stb);
		check_bit("reset we", 1'b0, we);
		check_bit("reset code npf", 1'b0, code_npf);
		check_bit("reset data npf", 1'b0, data_npf);

		foreach (rows[i])
			run_row(rows[i]);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: tb_mem.sv
`timescale 1ns/1ps

// bus memory model for the page tables, 64k bytes, random ack wait
module tb_mem (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	output logic        ack_o,
	output logic [31:0] dat_o
);

	logic [31:0] mem [16384];        // word index is adr[15:2]
	int          seed     = 32'h5af3;
	logic        ack_q    = 1'b0;
	logic [31:0] rdat_q   = '0;
	logic        busy_q   = 1'b0;    // wait count drawn for this cycle
	logic [1:0]  wait_q   = '0;
	int          rd_count = 0;
	int          wr_count = 0;
	logic [31:0] last_adr = '0;      // latest write, for write-back checks
	logic [31:0] last_dat = '0;

	assign ack_o = ack_q;
	assign dat_o = rdat_q;

	// unused words read as non-present entries (rd/wr/exec clear)
	initial begin
		for (int i = 0; i < 16384; i++)
			mem[i] = ((32'(i) << 2) ^ 32'h5a5a_0000) & 32'hffff_fff8;
	end

	// leaf slot: level-0 table of l1 index n sits at page n + 2
	function automatic logic [31:0] leaf_adr(input logic [31:0] va);
		return {20'(va[31:22]) + 20'd2, va[21:12], 2'b00};
	endfunction

	// level-1 entry goes under both table bases, leaf under its level-0 table
	task automatic map_page(input logic [31:0] va, input logic [31:0] leaf,
			input logic l1_bad, input logic [31:0] base_a, input logic [31:0] base_b);
		logic [31:0] l1;
		logic [31:0] la;
		l1 = l1_bad ? leaf : {20'(va[31:22]) + 20'd2, 12'h001};
		la = leaf_adr(va);
		mem[{base_a[15:12], va[31:22]}] = l1;
		mem[{base_b[15:12], va[31:22]}] = l1;
		mem[la[15:2]] = leaf;
	endtask

	// ----------------------------------------------------------
	// slave side, one ack pulse per cycle after 0..3 extra waits
	// ----------------------------------------------------------
	always @(posedge clk_i) begin
		if (rst_i) begin
			ack_q  <= 1'b0;
			busy_q <= 1'b0;
		end else if (ack_q) begin
			ack_q  <= 1'b0;   // master drops cyc on this edge
			busy_q <= 1'b0;
		end else if (cyc_i && stb_i) begin
			if (!busy_q) begin
				busy_q <= 1'b1;
				wait_q <= 2'($random(seed));
			end else if (wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else begin
				ack_q  <= 1'b1;
				rdat_q <= mem[adr_i[15:2]];
				if (we_i) begin
					mem[adr_i[15:2]] = dat_i;
					wr_count = wr_count + 1;
					last_adr = adr_i;
					last_dat = dat_i;
				end else begin
					rd_count = rd_count + 1;
				end
			end
		end
	end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

// testbench clock and synchronous reset source
module tb_clock (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;   // 8 ns period
	end

	// reset held high for the first 10 rising edges
	initial begin
		rst_o = 1'b1;
		repeat (10) @(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// File: mmu_top.sv
`timescale 1ns/1ps

module mmu_top
	import mmu_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	// control
	input  logic        paging_en_i,
	input  logic        invalidate_i,
	input  logic        invalidate_all_i,
	input  padr_t       pta_i,
	input  logic        clr_code_npf_i,
	input  logic        clr_data_npf_i,
	output logic        code_npf_o,
	output logic        data_npf_o,
	output pte_t        npf_pte_o,
	// code port
	input  logic        code_av_i,
	input  vadr_t       code_vadr_i,
	output xlat_t       code_xlat_o,
	output logic        code_rdy_o,
	// data port
	input  logic        data_av_i,
	input  vadr_t       data_vadr_i,
	input  logic        data_wr_i,
	output xlat_t       data_xlat_o,
	output logic        data_rdy_o,
	// table walk bus
	output logic        cyc_o,
	output logic        stb_o,
	output logic        we_o,
	output padr_t       adr_o,
	output logic [31:0] dat_o,
	input  logic        ack_i,
	input  logic [31:0] dat_i
);

	tlb_read_if rd_bus   ();
	tlb_fill_if fill_bus ();
	miss_if     miss_bus ();

	tlb_array i_tlb_array (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.pta_i            (pta_i),
		.invalidate_i     (invalidate_i),
		.invalidate_all_i (invalidate_all_i),
		.rd               (rd_bus.array),
		.fill             (fill_bus.array)
	);

	tlb_lookup i_tlb_lookup (
		.paging_en_i (paging_en_i),
		.code_av_i   (code_av_i),
		.code_vadr_i (code_vadr_i),
		.data_av_i   (data_av_i),
		.data_vadr_i (data_vadr_i),
		.data_wr_i   (data_wr_i),
		.code_xlat_o (code_xlat_o),
		.data_xlat_o (data_xlat_o),
		.code_rdy_o  (code_rdy_o),
		.data_rdy_o  (data_rdy_o),
		.rd          (rd_bus.lookup),
		.miss        (miss_bus.lookup)
	);

	page_walker i_page_walker (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.pta_i          (pta_i),
		.clr_code_npf_i (clr_code_npf_i),
		.clr_data_npf_i (clr_data_npf_i),
		.code_npf_o     (code_npf_o),
		.data_npf_o     (data_npf_o),
		.npf_pte_o      (npf_pte_o),
		.cyc_o          (cyc_o),
		.stb_o          (stb_o),
		.we_o           (we_o),
		.adr_o          (adr_o),
		.dat_o          (dat_o),
		.ack_i          (ack_i),
		.dat_i          (dat_i),
		.miss           (miss_bus.walker),
		.fill           (fill_bus.walker)
	);

endmodule

// File: page_walker.sv
`timescale 1ns/1ps
`include "mmu_settings.svh"

module page_walker
	import mmu_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  padr_t       pta_i,            // level-1 table base
	input  logic        clr_code_npf_i,
	input  logic        clr_data_npf_i,
	output logic        code_npf_o,       // sticky page-not-present
	output logic        data_npf_o,
	output pte_t        npf_pte_o,        // entry that faulted
	output logic        cyc_o,
	output logic        stb_o,
	output logic        we_o,
	output padr_t       adr_o,
	output logic [31:0] dat_o,
	input  logic        ack_i,
	input  logic [31:0] dat_i,
	miss_if.walker      miss,
	tlb_fill_if.walker  fill
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_L1_RD,    // read level-1 entry
		ST_L0_RD,    // read leaf
		ST_PTE_WR,   // accessed/dirty write-back
		ST_FILL
	} state_t;

	state_t      state_q;
	vadr_t       va_q;        // captured miss address
	logic        is_data_q;
	logic        wr_q;
	pte_t        pte_q;       // last entry read
	padr_t       bus_adr;
	logic [31:0] wb_dat;

	// address for the next bus cycle
	always_comb begin
		case (state_q)
			ST_L1_RD: bus_adr = {pta_i[31:`PAGE_SHIFT], va_q[`VA_L1_MSB:`VA_L1_LSB], 2'b00};
			ST_L0_RD: bus_adr = {pte_q.ppn, va_q[`VA_L0_MSB:`VA_L0_LSB], 2'b00};
			default:  bus_adr = adr_o;   // write-back reuses the leaf address
		endcase
	end

	// leaf with accessed set, dirty too on a write miss
	always_comb begin
		wb_dat                 = pte_q;
		wb_dat[`PTE_ACC_BIT]   = 1'b1;
		wb_dat[`PTE_DIRTY_BIT] = pte_q.dirty | wr_q;
	end

	// ----------------------------------------------------------
	// walk fsm and bus master
	// ----------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q    <= ST_IDLE;
			cyc_o      <= 1'b0;
			stb_o      <= 1'b0;
			we_o       <= 1'b0;
			code_npf_o <= 1'b0;
			data_npf_o <= 1'b0;
		end else begin
			if (clr_code_npf_i) code_npf_o <= 1'b0;
			if (clr_data_npf_i) data_npf_o <= 1'b0;

			case (state_q)
				ST_IDLE: begin
					if (miss.miss && !code_npf_o && !data_npf_o) begin
						va_q      <= miss.miss_vadr;
						is_data_q <= miss.miss_is_data;
						wr_q      <= miss.miss_wr;
						state_q   <= ST_L1_RD;
					end
				end
				ST_L1_RD, ST_L0_RD, ST_PTE_WR: begin
					if (!cyc_o) begin
						cyc_o <= 1'b1;   // open cycle, held until ack
						stb_o <= 1'b1;
						we_o  <= (state_q == ST_PTE_WR);
						adr_o <= bus_adr;
						dat_o <= wb_dat;
					end else if (ack_i) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						we_o  <= 1'b0;
						if (state_q == ST_PTE_WR) begin
							state_q <= ST_FILL;
						end else if (pte_present(dat_i)) begin
							pte_q   <= dat_i;
							state_q <= (state_q == ST_L1_RD) ? ST_L0_RD : ST_PTE_WR;
						end else begin
							code_npf_o <= !is_data_q;   // fault on the side that missed
							data_npf_o <= is_data_q;
							npf_pte_o  <= dat_i;
							state_q    <= ST_IDLE;
						end
					end
				end
				ST_FILL:  state_q <= ST_IDLE;   // array writes on this edge
				default:  state_q <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------
	// tlb fill, one cycle
	// ----------------------------------------------------------
	always_comb begin
		fill.fill_we         = (state_q == ST_FILL);
		fill.fill_vadr       = va_q;
		fill.fill_data.ppn   = pte_q.ppn;
		fill.fill_data.priv  = pte_q.priv;
		fill.fill_data.cache = pte_q.cache;
		fill.fill_data.exec  = pte_q.exec;
		fill.fill_data.wr    = pte_q.wr;
		fill.fill_data.rd    = pte_q.rd;
	end

endmodule

// File: tlb_lookup.sv
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tlb_lookup
	import mmu_pkg::*;
(
	input  logic  paging_en_i,
	input  logic  code_av_i,      // code address valid
	input  vadr_t code_vadr_i,
	input  logic  data_av_i,
	input  vadr_t data_vadr_i,
	input  logic  data_wr_i,      // cpu write cycle
	output xlat_t code_xlat_o,
	output xlat_t data_xlat_o,
	output logic  code_rdy_o,
	output logic  data_rdy_o,
	tlb_read_if.lookup rd,
	miss_if.lookup     miss
);

	logic code_hit;
	logic data_hit;
	logic code_miss;
	logic data_miss;

	// ----------------------------------------------------------
	// one port's translation, shared by code and data
	// ----------------------------------------------------------
	function automatic xlat_t xlate(
		input  vadr_t                va,
		input  vtag_t                tag [`TLB_WAYS],
		input  tlb_data_t            dat [`TLB_WAYS],
		input  logic [`TLB_WAYS-1:0] vld,
		output logic                 hit
	);
		xlat_t x;
		x      = '0;
		x.padr = va;
		hit    = 1'b0;
		if (!paging_en_i || va[31:`VTAG_LSB] == `UNMAPPED_TOP) begin
			hit     = 1'b1;   // bypass, full access, supervisor
			x.cache = 1'b1;
			x.rd    = 1'b1;
			x.wr    = 1'b1;
			x.exec  = 1'b1;
			x.valid = 1'b1;
		end else begin
			for (int w = 0; w < `TLB_WAYS; w++) begin
				if (vld[w] && tag[w] == va[31:`VTAG_LSB]) begin
					hit     = 1'b1;
					x.padr  = {dat[w].ppn, va[`PAGE_SHIFT-1:0]};   // keep page offset
					x.priv  = dat[w].priv;
					x.cache = dat[w].cache;
					x.rd    = dat[w].rd;
					x.wr    = dat[w].wr;
					x.exec  = dat[w].exec;
					x.valid = dat[w].rd | dat[w].wr | dat[w].exec;
				end
			end
		end
		return x;
	endfunction

	// set index and tag out to the array
	assign rd.code_idx  = code_vadr_i[`PAGE_SHIFT +: `TLB_IDX_W];
	assign rd.data_idx  = data_vadr_i[`PAGE_SHIFT +: `TLB_IDX_W];
	assign rd.code_vtag = code_vadr_i[31:`VTAG_LSB];

	always_comb
		code_xlat_o = xlate(code_vadr_i, rd.code_tag, rd.code_data, rd.code_vld, code_hit);

	always_comb
		data_xlat_o = xlate(data_vadr_i, rd.data_tag, rd.data_data, rd.data_vld, data_hit);

	assign code_rdy_o = code_hit;
	assign data_rdy_o = data_hit;

	// ----------------------------------------------------------
	// miss request, data side first
	// ----------------------------------------------------------
	assign code_miss = code_av_i && !code_hit;
	assign data_miss = data_av_i && !data_hit;

	assign miss.miss         = code_miss | data_miss;
	assign miss.miss_is_data = data_miss;
	assign miss.miss_vadr    = data_miss ? data_vadr_i : code_vadr_i;
	assign miss.miss_wr      = data_miss & data_wr_i;

endmodule

// File: tlb_array.sv
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tlb_array
	import mmu_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_i,
	input  padr_t pta_i,              // page table base
	input  logic  invalidate_i,       // drop entry of current code address
	input  logic  invalidate_all_i,
	tlb_read_if.array rd,
	tlb_fill_if.array fill
);

	localparam int WAY_W = $clog2(`TLB_WAYS);

	logic [`TLB_WAYS-1:0] vld_q [`TLB_SETS];   // valid per set, per way
	logic [WAY_W-1:0]     rr_q;                // round-robin victim
	logic [WAY_W-1:0]     victim;
	logic                 free;                // set has an invalid way
	padr_t                pta_q;
	logic                 pta_chg;
	tlb_idx_t             fill_idx;
	logic                 fill_present;

	assign fill_idx     = fill.fill_vadr[`PAGE_SHIFT +: `TLB_IDX_W];
	assign fill_present = fill.fill_data.rd | fill.fill_data.wr | fill.fill_data.exec;

	// ----------------------------------------------------------
	// ways
	// ----------------------------------------------------------
	for (genvar g = 0; g < `TLB_WAYS; g++) begin : g_way
		logic we;
		assign we = fill.fill_we && (victim == WAY_W'(g));

		tlb_ram #(.T(vtag_t)) i_tag (
			.clk_i (clk_i),
			.we_i  (we),
			.wa_i  (fill_idx),
			.wd_i  (fill.fill_vadr[31:`VTAG_LSB]),
			.ra0_i (rd.code_idx),
			.ra1_i (rd.data_idx),
			.rd0_o (rd.code_tag[g]),
			.rd1_o (rd.data_tag[g])
		);

		tlb_ram #(.T(tlb_data_t)) i_data (
			.clk_i (clk_i),
			.we_i  (we),
			.wa_i  (fill_idx),
			.wd_i  (fill.fill_data),
			.ra0_i (rd.code_idx),
			.ra1_i (rd.data_idx),
			.rd0_o (rd.code_data[g]),
			.rd1_o (rd.data_data[g])
		);
	end

	assign rd.code_vld = vld_q[rd.code_idx];
	assign rd.data_vld = vld_q[rd.data_idx];

	// ----------------------------------------------------------
	// victim: lowest empty way, else round robin
	// ----------------------------------------------------------
	always_comb begin
		victim = rr_q;
		free   = 1'b0;
		for (int w = `TLB_WAYS - 1; w >= 0; w--) begin
			if (!vld_q[fill_idx][w]) begin
				victim = WAY_W'(w);   // last hit wins -> lowest index
				free   = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			rr_q <= '0;
		else if (fill.fill_we && !free)
			rr_q <= rr_q + 1'b1;   // only advances when it was used
	end

	// a new table base makes every entry stale
	always_ff @(posedge clk_i)
		pta_q <= pta_i;
	assign pta_chg = (pta_q != pta_i);

	always_ff @(posedge clk_i) begin
		if (rst_i || invalidate_all_i || pta_chg) begin
			for (int s = 0; s < `TLB_SETS; s++)
				vld_q[s] <= '0;
		end else begin
			if (fill.fill_we)
				vld_q[fill_idx][victim] <= fill_present;   // non-present leaves stay invalid
			if (invalidate_i) begin
				for (int w = 0; w < `TLB_WAYS; w++)
					if (rd.code_tag[w] == rd.code_vtag)
						vld_q[rd.code_idx][w] <= 1'b0;
			end
		end
	end

endmodule

// File: tlb_ram.sv
`timescale 1ns/1ps
`include "mmu_settings.svh"

// one tlb way: sync write, two async reads (code / data)
module tlb_ram
	import mmu_pkg::*;
#(
	parameter type T = logic
) (
	input  logic     clk_i,
	input  logic     we_i,
	input  tlb_idx_t wa_i,
	input  T         wd_i,
	input  tlb_idx_t ra0_i,   // code port
	input  tlb_idx_t ra1_i,   // data port
	output T         rd0_o,
	output T         rd1_o
);

	T mem [`TLB_SETS];   // payload only, valid bits live in tlb_array

	always_ff @(posedge clk_i) begin
		if (we_i)
			mem[wa_i] <= wd_i;
	end

	// reads are combinational so a hit resolves in the address cycle
	assign rd0_o = mem[ra0_i];
	assign rd1_o = mem[ra1_i];

endmodule

// File: mmu_if.sv
`timescale 1ns/1ps
`include "mmu_settings.svh"

// lookup -> array index, array -> lookup per-way contents (all comb)
interface tlb_read_if
	import mmu_pkg::*;
();
	tlb_idx_t                code_idx;
	tlb_idx_t                data_idx;
	vtag_t                   code_vtag;               // current code tag, used by invalidate
	vtag_t                   code_tag  [`TLB_WAYS];
	vtag_t                   data_tag  [`TLB_WAYS];
	tlb_data_t               code_data [`TLB_WAYS];
	tlb_data_t               data_data [`TLB_WAYS];
	logic [`TLB_WAYS-1:0]    code_vld;
	logic [`TLB_WAYS-1:0]    data_vld;

	modport array  (input  code_idx, data_idx, code_vtag,
	                output code_tag, data_tag, code_data, data_data, code_vld, data_vld);
	modport lookup (output code_idx, data_idx, code_vtag,
	                input  code_tag, data_tag, code_data, data_data, code_vld, data_vld);
endinterface

// walker -> array, one cycle write strobe
interface tlb_fill_if
	import mmu_pkg::*;
();
	logic      fill_we;
	vadr_t     fill_vadr;
	tlb_data_t fill_data;

	modport walker (output fill_we, fill_vadr, fill_data);
	modport array  (input  fill_we, fill_vadr, fill_data);
endinterface

// lookup -> walker, levels held until the fill makes the address hit
interface miss_if
	import mmu_pkg::*;
();
	logic  miss;
	vadr_t miss_vadr;
	logic  miss_is_data;   // data side won priority
	logic  miss_wr;        // data write, sets dirty on write-back

	modport lookup (output miss, miss_vadr, miss_is_data, miss_wr);
	modport walker (input  miss, miss_vadr, miss_is_data, miss_wr);
endinterface

// File: mmu_pkg.sv
`include "mmu_settings.svh"

package mmu_pkg;

	typedef logic [31:0] vadr_t;                  // virtual address
	typedef logic [31:0] padr_t;                  // physical address
	typedef logic [31-`VTAG_LSB:0] vtag_t;        // vadr[31:16]
	typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;     // vadr[15:12]

	// page table entry as it sits in memory
	typedef struct packed {
		logic [19:0] ppn;      // physical page / next table base
		logic [1:0]  spare;
		logic        dirty;
		logic        accessed;
		logic [3:0]  priv;     // 0 = supervisor
		logic        cache;
		logic        exec;
		logic        wr;
		logic        rd;
	} pte_t;

	// what the tlb keeps of a leaf, 28 bits
	typedef struct packed {
		logic [19:0] ppn;
		logic [3:0]  priv;
		logic        cache;
		logic        exec;
		logic        wr;
		logic        rd;
	} tlb_data_t;

	// translation result per port
	typedef struct packed {
		padr_t       padr;
		logic [3:0]  priv;
		logic        cache;
		logic        rd;
		logic        wr;
		logic        exec;
		logic        valid;    // any of rd/wr/exec
	} xlat_t;

	function automatic logic pte_present(input pte_t p);
		return p.rd | p.wr | p.exec;
	endfunction

endpackage

// File: mmu_settings.svh
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// ----------------------------------------------------------
// tlb geometry
// ----------------------------------------------------------
`define TLB_WAYS       4         // parallel compares per set
`define TLB_SETS       16        // sets per way
`define TLB_IDX_W      4         // set index, vadr[15:12]

// ----------------------------------------------------------
// address split
// ----------------------------------------------------------
`define PAGE_SHIFT     12        // 4k pages
`define VTAG_LSB       16        // tag is vadr[31:16]
`define UNMAPPED_TOP   16'h0000  // upper half that bypasses translation
`define VA_L1_MSB      31        // level-1 table index
`define VA_L1_LSB      22
`define VA_L0_MSB      21        // level-0 table index
`define VA_L0_LSB      12

// ----------------------------------------------------------
// pte bits written back by the walker
// ----------------------------------------------------------
`define PTE_ACC_BIT    8
`define PTE_DIRTY_BIT  9

`endif
